// ==== files.f ====
src/vaddrgen_pkg.sv
src/vaddrgen_fifo.sv
src/vmem_decoder.sv
src/ax_sequencer.sv
src/vaddrgen_top.sv
test/tb_vaddrgen.sv

// ==== Bender.yml ====
package:
  name: vaddrgen

dependencies: {}

sources:
  - src/vaddrgen_pkg.sv
  - src/vaddrgen_fifo.sv
  - src/vmem_decoder.sv
  - src/ax_sequencer.sv
  - src/vaddrgen_top.sv
  - target: simulation
    files:
      - test/tb_vaddrgen.sv

// ==== test/tb_vaddrgen.sv ====
////////////////////////////////////////
// Vector address generator testbench
// Random requests checked against a reference model
////////////////////////////////////////

`default_nettype none

module tb_vaddrgen;

  import vaddrgen_pkg::*;

  localparam int ClkPeriod   = 40;
  localparam int Quarter     = ClkPeriod / 4;
  localparam int NumReqs     = 60;
  localparam int MaxVl       = 255;
  localparam int StallFactor = 8;
  // Worst case cycles per request times the number of requests
  localparam int TimeLimit   = NumReqs * MaxVl * StallFactor * ClkPeriod;

  logic      clk_i;
  logic      rst_ni;
  vmem_req_t req_i;
  logic      req_valid_i;
  logic      req_ready_o;
  ax_req_t   ax_o;
  logic      ax_valid_o;
  logic      ax_ready_i;
  lsu_cmd_t  lsu_cmd_o;
  logic      lsu_valid_o;
  logic      lsu_ready_i;
  logic      core_st_pending_i;
  logic      ack_o;
  logic      ack_error_o;

  // Reference model state
  ax_req_t   exp_ax[$];
  lsu_cmd_t  exp_lsu[$];
  logic      exp_err[$];
  int        exp_ax_at[$];
  int        ax_total;
  int        ax_done;
  logic      ax_prev_stalled;
  int        stall_left;
  integer    seed;
  vmem_req_t req;

  vaddrgen_top #(
    .InQueueDepth (2),
    .CmdQueueDepth(4)
  ) dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .ax_o             (ax_o),
    .ax_valid_o       (ax_valid_o),
    .ax_ready_i       (ax_ready_i),
    .lsu_cmd_o        (lsu_cmd_o),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_ready_i      (lsu_ready_i),
    .core_st_pending_i(core_st_pending_i),
    .ack_o            (ack_o),
    .ack_error_o      (ack_error_o)
  );

  initial begin
    clk_i = 1'b0;
  end

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic report_failure();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      report_failure();
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // One address request and its twin command
  task automatic expect_issue(input ax_req_t a);
    exp_ax.push_back(a);
    exp_lsu.push_back(lsu_cmd_t'(a));
    ax_total++;
  endtask

  task automatic expand_request(input vmem_req_t r);
    ax_req_t              a;
    int                   elem;
    int                   words;
    logic [AddrWidth-1:0] addr;
    elem = 1 << r.eew;
    if ((r.addr % elem) != 0) begin
      // Error ack only
      exp_err.push_back(1'b1);
    end else if (r.is_burst) begin
      // Bus words from the base word up to the last byte
      words     = (int'(r.addr[2:0]) + int'(r.vl) * elem + BusBytes - 1) / BusBytes;
      a.addr    = r.addr;
      a.len     = 8'(words - 1);
      a.size    = 3'd3;
      a.is_load = r.is_load;
      expect_issue(a);
      exp_err.push_back(1'b0);
    end else begin
      addr = r.addr;
      for (int i = 0; i < int'(r.vl); i++) begin
        a.addr    = addr;
        a.len     = '0;
        a.size    = 3'(r.eew);
        a.is_load = r.is_load;
        expect_issue(a);
        addr      = addr + r.stride;
      end
      exp_err.push_back(1'b0);
    end
    // Address handshakes done by the time of this ack
    exp_ax_at.push_back(ax_total);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Next falling edge with fresh ready and stall values
  task automatic advance_cycle();
    @(negedge clk_i);
    ax_ready_i  = ($random(seed) & 3) != 0;
    lsu_ready_i = ($random(seed) & 1) != 0;
    if (stall_left > 0) begin
      stall_left--;
    end else if (($random(seed) & 31) == 0) begin
      stall_left = 3 + ($random(seed) & 15);
    end
    core_st_pending_i = (stall_left > 0);
  endtask

  task automatic random_request(output vmem_req_t r);
    logic [31:0] rnd;
    rnd        = $random(seed);
    r.eew      = eew_e'(rnd[1:0]);
    r.is_load  = rnd[2];
    r.is_burst = rnd[3];
    if (r.is_burst) begin
      r.vl = 8'(1 + ($unsigned($random(seed)) % MaxVl));
    end else if (rnd[7:4] == 4'h0) begin
      // Occasional full-length strided vector
      r.vl = 8'(MaxVl);
    end else begin
      r.vl = 8'(1 + ($unsigned($random(seed)) % 24));
    end
    r.stride = $random(seed);
    r.addr   = $random(seed);
    if ((rnd[10:8] == 3'd0) && (r.eew != eew_byte)) begin
      // Misaligned base
      r.addr[0] = 1'b1;
    end else begin
      r.addr = r.addr & ~((32'd1 << r.eew) - 32'd1);
    end
  endtask

  // Hold the request until the input queue takes it
  task automatic send_request(input vmem_req_t r);
    logic taken;
    req_i       = r;
    req_valid_i = 1'b1;
    taken       = 1'b0;
    while (!taken) begin
      #(Quarter);
      taken = req_ready_o;
      advance_cycle();
    end
    req_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Monitor sampling a quarter period after the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    #(Quarter);
    if (rst_ni) begin
      // Only a request held from the last cycle may stay visible
      if (core_st_pending_i && ax_valid_o && !ax_prev_stalled) begin
        $display("new address request presented while a scalar store is pending");
        report_failure();
      end
      if (ax_valid_o && ax_ready_i) begin
        if (exp_ax.size() == 0) begin
          $display("address request seen with none expected");
          report_failure();
        end
        if (lsu_valid_o && (lsu_cmd_o.is_load != ax_o.is_load)) begin
          $display("address request issued against an opposite direction command");
          report_failure();
        end
        check_value("ax_o", ax_o, exp_ax.pop_front());
        ax_done++;
      end
      if (lsu_valid_o && lsu_ready_i) begin
        if (exp_lsu.size() == 0) begin
          $display("unit command seen with none expected");
          report_failure();
        end
        check_value("lsu_cmd_o", lsu_cmd_o, exp_lsu.pop_front());
      end
      if (ack_error_o && !ack_o) begin
        $display("error flag raised without an ack");
        report_failure();
      end
      if (ack_o) begin
        if (exp_err.size() == 0) begin
          $display("ack seen with no request outstanding");
          report_failure();
        end
        check_value("ack_error_o", ack_error_o, exp_err.pop_front());
        check_value("ax_o handshakes at ack_o", ax_done, exp_ax_at.pop_front());
      end
      ax_prev_stalled = ax_valid_o && !ax_ready_i;
    end
  end

  // Watchdog
  initial begin
    #(TimeLimit);
    $display("timeout, requests did not complete within the time limit");
    report_failure();
  end

  initial begin
    seed              = 32'hab27;
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    ax_ready_i        = 1'b0;
    lsu_ready_i       = 1'b0;
    core_st_pending_i = 1'b0;
    ax_total          = 0;
    ax_done           = 0;
    ax_prev_stalled   = 1'b0;
    stall_left        = 0;
    repeat (4) @(negedge clk_i);
    // Idle outputs while in reset
    check_value("req_ready_o", req_ready_o, 1'b1);
    check_value("ax_valid_o", ax_valid_o, 1'b0);
    check_value("lsu_valid_o", lsu_valid_o, 1'b0);
    check_value("ack_o", ack_o, 1'b0);
    check_value("ack_error_o", ack_error_o, 1'b0);
    rst_ni = 1'b1;
    for (int n = 0; n < NumReqs; n++) begin
      random_request(req);
      expand_request(req);
      send_request(req);
      repeat ($unsigned($random(seed)) % 3) advance_cycle();
    end
    // Wait for every ack, then for the command queue to run dry
    while (exp_err.size() != 0) begin
      advance_cycle();
    end
    while (lsu_valid_o) begin
      advance_cycle();
    end
    repeat (4) advance_cycle();
    // Every expected unit command has left the queue
    check_value("lsu_cmd_o outstanding", exp_lsu.size(), 0);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/vaddrgen_top.sv ====
////////////////////////////////////////
// Vector address generator top level
// Input queue, decoder, sequencer and command queue
////////////////////////////////////////

`default_nettype none

module vaddrgen_top #(
  parameter int unsigned InQueueDepth  = vaddrgen_pkg::InQueueDepth,
  parameter int unsigned CmdQueueDepth = vaddrgen_pkg::CmdQueueDepth
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Vector memory requests
  input  wire vaddrgen_pkg::vmem_req_t req_i,
  input  wire logic                    req_valid_i,
  output logic                         req_ready_o,
  // Address channel
  output vaddrgen_pkg::ax_req_t        ax_o,
  output logic                         ax_valid_o,
  input  wire logic                    ax_ready_i,
  // Load/store unit commands
  output vaddrgen_pkg::lsu_cmd_t       lsu_cmd_o,
  output logic                         lsu_valid_o,
  input  wire logic                    lsu_ready_i,
  // Core status and completion
  input  wire logic                    core_st_pending_i,
  output logic                         ack_o,
  output logic                         ack_error_o
);

  import vaddrgen_pkg::*;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Input queue to decoder
  vmem_req_t in_req;
  logic      in_valid;
  logic      in_ready;
  // Decoder to sequencer
  vmem_dec_t dec;
  logic      dec_valid;
  logic      dec_ready;
  // Sequencer to command queue
  lsu_cmd_t  cmd;
  logic      cmd_valid;
  logic      cmd_ready;
  logic      cmd_empty;

  vaddrgen_fifo #(
    .Depth(InQueueDepth),
    .dtype(vmem_req_t)
  ) i_in_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (req_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_o (in_req),
    .valid_o(in_valid),
    .ready_i(in_ready),
    .empty_o()
  );

  vmem_decoder i_decoder (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (in_req),
    .req_valid_i(in_valid),
    .req_ready_o(in_ready),
    .dec_o      (dec),
    .dec_valid_o(dec_valid),
    .dec_ready_i(dec_ready)
  );

  ax_sequencer i_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dec_i            (dec),
    .dec_valid_i      (dec_valid),
    .dec_ready_o      (dec_ready),
    .core_st_pending_i(core_st_pending_i),
    .ax_o             (ax_o),
    .ax_valid_o       (ax_valid_o),
    .ax_ready_i       (ax_ready_i),
    .cmd_o            (cmd),
    .cmd_valid_o      (cmd_valid),
    .cmd_ready_i      (cmd_ready),
    .cmd_empty_i      (cmd_empty),
    // Direction of the oldest queued command
    .cmd_head_load_i  (lsu_cmd_o.is_load),
    .ack_o            (ack_o),
    .ack_error_o      (ack_error_o)
  );

  // Head of this queue drives the unit command outputs
  vaddrgen_fifo #(
    .Depth(CmdQueueDepth),
    .dtype(lsu_cmd_t)
  ) i_cmd_queue (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (cmd),
    .valid_i(cmd_valid),
    .ready_o(cmd_ready),
    .data_o (lsu_cmd_o),
    .valid_o(lsu_valid_o),
    .ready_i(lsu_ready_i),
    .empty_o(cmd_empty)
  );

endmodule

`default_nettype wire

// ==== src/ax_sequencer.sv ====
////////////////////////////////////////
// Address request sequencer
// Issues burst or strided requests with matching unit commands
////////////////////////////////////////

`default_nettype none

module ax_sequencer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Decoded request
  input  wire vaddrgen_pkg::vmem_dec_t dec_i,
  input  wire logic                    dec_valid_i,
  output logic                         dec_ready_o,
  // Scalar store pending in the core
  input  wire logic                    core_st_pending_i,
  // Address channel
  output vaddrgen_pkg::ax_req_t        ax_o,
  output logic                         ax_valid_o,
  input  wire logic                    ax_ready_i,
  // Command queue push side and head status
  output vaddrgen_pkg::lsu_cmd_t       cmd_o,
  output logic                         cmd_valid_o,
  input  wire logic                    cmd_ready_i,
  input  wire logic                    cmd_empty_i,
  input  wire logic                    cmd_head_load_i,
  // Completion
  output logic                         ack_o,
  output logic                         ack_error_o
);

  import vaddrgen_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_err_ack,
    st_wait_st,
    st_request
  } seq_state_e;

  seq_state_e state_d, state_q;
  // Current request, address and count advance per element
  vmem_dec_t  cur_d, cur_q;
  // Request shown on the address channel, command already pushed
  logic       pending_d, pending_q;
  logic       issue_ok;
  logic       ax_hs;

  // Room in the queue, no scalar store, same direction as queued entries
  assign issue_ok = cmd_ready_i && !core_st_pending_i &&
                    (cmd_empty_i || (cmd_head_load_i == cur_q.is_load));
  assign ax_hs    = ax_valid_o && ax_ready_i;

  // Address request and command carry the same content
  assign ax_o.addr    = cur_q.addr;
  assign ax_o.len     = cur_q.is_burst ? cur_q.count : '0;
  assign ax_o.size    = cur_q.size;
  assign ax_o.is_load = cur_q.is_load;

  assign cmd_o.addr    = ax_o.addr;
  assign cmd_o.len     = ax_o.len;
  assign cmd_o.size    = ax_o.size;
  assign cmd_o.is_load = ax_o.is_load;

  always_comb begin
    state_d     = state_q;
    cur_d       = cur_q;
    pending_d   = pending_q;
    dec_ready_o = 1'b0;
    ax_valid_o  = 1'b0;
    cmd_valid_o = 1'b0;
    ack_o       = 1'b0;
    ack_error_o = 1'b0;

    case (state_q)
      st_idle: begin
        dec_ready_o = 1'b1;
        if (dec_valid_i) begin
          cur_d = dec_i;
          if (dec_i.misaligned) begin
            state_d = st_err_ack;
          end else if (core_st_pending_i) begin
            state_d = st_wait_st;
          end else begin
            state_d = st_request;
          end
        end
      end
      // Misaligned base, report and drop
      st_err_ack: begin
        ack_o       = 1'b1;
        ack_error_o = 1'b1;
        state_d     = st_idle;
      end
      st_wait_st: begin
        if (!core_st_pending_i) begin
          state_d = st_request;
        end
      end
      st_request: begin
        // Once shown the request holds until the handshake
        ax_valid_o  = pending_q || issue_ok;
        // Command goes into the queue on the first cycle only
        cmd_valid_o = !pending_q && issue_ok;
        if (ax_hs) begin
          pending_d = 1'b0;
          if (cur_q.is_burst || (cur_q.count == MaxBeatsWidth'(1))) begin
            ack_o   = 1'b1;
            state_d = st_idle;
          end else begin
            // Next element
            cur_d.count = cur_q.count - 1'b1;
            cur_d.addr  = cur_q.addr + cur_q.stride;
          end
        end else if (ax_valid_o) begin
          pending_d = 1'b1;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

  // A stalled address request keeps valid and payload
  a_ax_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ax_valid_o && !ax_ready_i) |=> (ax_valid_o && $stable(ax_o)));

endmodule

`default_nettype wire

// ==== src/vmem_decoder.sv ====
////////////////////////////////////////
// Vector memory request decoder
// Alignment check, beat count and size, one register stage
////////////////////////////////////////

`default_nettype none

module vmem_decoder (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Request side
  input  wire vaddrgen_pkg::vmem_req_t req_i,
  input  wire logic                    req_valid_i,
  output logic                         req_ready_o,
  // Decoded side
  output vaddrgen_pkg::vmem_dec_t      dec_o,
  output logic                         dec_valid_o,
  input  wire logic                    dec_ready_i
);

  import vaddrgen_pkg::*;

  // Enough bits for the byte offset plus the full byte length
  localparam int unsigned SpanWidth = BusSizeLog + MaxBeatsWidth;

  vmem_dec_t            dec_d, dec_q;
  logic                 valid_q;
  logic                 accept;
  logic [BusSizeLog:0]  elem_bytes;
  logic [BusSizeLog:0]  elem_mask;
  logic [SpanWidth-1:0] byte_span;

  // Element size in bytes and its low-bit mask
  assign elem_bytes = {{BusSizeLog{1'b0}}, 1'b1} << req_i.eew;
  assign elem_mask  = elem_bytes - 1'b1;

  // Offset of the last byte from the bus word of the base address
  assign byte_span = SpanWidth'(req_i.addr[BusSizeLog-1:0])
                   + (SpanWidth'(req_i.vl) << req_i.eew)
                   - SpanWidth'(1);

  always_comb begin
    dec_d.addr       = req_i.addr;
    dec_d.stride     = req_i.stride;
    dec_d.is_load    = req_i.is_load;
    dec_d.is_burst   = req_i.is_burst;
    // Any set bit below the element width
    dec_d.misaligned = |(req_i.addr[BusSizeLog-1:0] & elem_mask[BusSizeLog-1:0]);
    if (req_i.is_burst) begin
      // Full bus width, bus words touched minus one
      dec_d.size  = 3'(BusSizeLog);
      dec_d.count = byte_span[SpanWidth-1:BusSizeLog];
    end else begin
      // One element per request
      dec_d.size  = 3'(req_i.eew);
      dec_d.count = req_i.vl;
    end
  end

  // Take a new request when empty or when the held one leaves
  assign req_ready_o = !valid_q || dec_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = valid_q;

  // Zero-length vectors never reach the sequencer
  a_vl_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (req_i.vl != '0));

endmodule

`default_nettype wire

// ==== src/vaddrgen_fifo.sv ====
////////////////////////////////////////
// Generic synchronous FIFO
// Valid/ready on both sides, payload set by a type parameter
////////////////////////////////////////

`default_nettype none

module vaddrgen_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         dtype = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // Write side
  input  wire dtype data_i,
  input  wire logic valid_i,
  output logic      ready_o,
  // Read side
  output dtype      data_o,
  output logic      valid_o,
  input  wire logic ready_i,
  output logic      empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // Payload storage
  dtype mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] usage_q;
  logic                full;
  logic                push;
  logic                pop;

  assign full    = (usage_q == CntWidth'(Depth));
  assign empty_o = (usage_q == '0);
  assign ready_o = !full;
  assign valid_o = !empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  // Transfers on each side
  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop && !push) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Occupancy never grows past the number of slots
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    usage_q <= CntWidth'(Depth));

  // Pointers meet only when the queue is empty or full
  a_ptr_consistent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ptr_q == rd_ptr_q) == (empty_o || full));

endmodule

`default_nettype wire

// ==== src/vaddrgen_pkg.sv ====
////////////////////////////////////////
// Vector address generator package
// Shared widths, element encodings and request structs
////////////////////////////////////////

`default_nettype none

package vaddrgen_pkg;

  // Datapath widths
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned VlWidth       = 8;
  localparam int unsigned BusBytes      = 8;
  localparam int unsigned BusSizeLog    = 3;
  localparam int unsigned MaxBeatsWidth = 8;

  // Default queue depths
  localparam int unsigned InQueueDepth  = 2;
  localparam int unsigned CmdQueueDepth = 4;

  // Element width, code equals log2 of the element size in bytes
  typedef enum logic [1:0] {
    eew_byte   = 2'd0,
    eew_half   = 2'd1,
    eew_word   = 2'd2,
    eew_double = 2'd3
  } eew_e;

  // Incoming vector memory request
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [VlWidth-1:0]   vl;
    logic [AddrWidth-1:0] stride;
    eew_e                 eew;
    logic                 is_load;
    logic                 is_burst;
  } vmem_req_t;

  // Decoded request, count is elements left or beats minus one
  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic [AddrWidth-1:0]     stride;
    logic [MaxBeatsWidth-1:0] count;
    logic [2:0]               size;
    logic                     is_load;
    logic                     is_burst;
    logic                     misaligned;
  } vmem_dec_t;

  // Address channel request
  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic [MaxBeatsWidth-1:0] len;
    logic [2:0]               size;
    logic                     is_load;
  } ax_req_t;

  // Command towards the load/store units
  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic [MaxBeatsWidth-1:0] len;
    logic [2:0]               size;
    logic                     is_load;
  } lsu_cmd_t;

endpackage

`default_nettype wire
